/* Bender.yml */
package:
  name: rec_df_buffer

sources:
  - rec_df_pkg.sv
  - rec_df_ram.sv
  - rec_blk_writer.sv
  - df_edge_sequencer.sv
  - rec_df_ram_ctrl.sv
  - rec_df_buffer_top.sv
  - target: test
    files:
      - rec_df_buffer_checker.sv
      - tb_rec_df_buffer.sv

/* df_edge_sequencer.sv */
`timescale 1ns/1ps

module df_edge_sequencer (
	input  logic       clk,
	input  logic       reset_n,
	input  logic       df_start,
	output logic       seq_active,
	output logic [5:0] edge_cnt,
	output logic [1:0] line_cnt
);

	rec_df_pkg::seq_state_e state;

	// Final line of final edge
	logic last_line;

	assign last_line = (edge_cnt == 6'(rec_df_pkg::EDGE_LAST)) && (line_cnt == 2'd3);

	// ----------------------------------------------------------------------
	// Edge / line walk, 48 x 4 cycles per macroblock
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state    <= rec_df_pkg::SEQ_IDLE;
			edge_cnt <= 6'd0;
			line_cnt <= 2'd0;
		end
		else
		begin
			case (state)
				rec_df_pkg::SEQ_IDLE:
				begin
					edge_cnt <= 6'd0;
					line_cnt <= 2'd0;
					if (df_start)
					begin
						state <= rec_df_pkg::SEQ_RUN;
					end
				end
				rec_df_pkg::SEQ_RUN:
				begin
					// df_start ignored here
					line_cnt <= line_cnt + 2'd1;
					if (last_line)
					begin
						state    <= rec_df_pkg::SEQ_IDLE;
						edge_cnt <= 6'd0;
					end
					else if (line_cnt == 2'd3)
					begin
						edge_cnt <= edge_cnt + 6'd1;
					end
				end
				default:
				begin
					state <= rec_df_pkg::SEQ_IDLE;
				end
			endcase
		end
	end

	// Also the top-level busy flag
	assign seq_active = (state == rec_df_pkg::SEQ_RUN);

endmodule

/* filelist.f */
rec_df_pkg.sv
rec_df_ram.sv
rec_blk_writer.sv
df_edge_sequencer.sv
rec_df_ram_ctrl.sv
rec_df_buffer_top.sv
rec_df_buffer_checker.sv
tb_rec_df_buffer.sv

/* rec_blk_writer.sv */
`timescale 1ns/1ps

module rec_blk_writer (
	input  logic       clk,
	input  logic       reset_n,
	input  logic       blk_start,
	input  logic [4:0] blk_index,
	output logic       wr_active,
	output logic [1:0] row_cnt,
	output logic [4:0] blk_latched
);

	rec_df_pkg::seq_state_e state;

	// ----------------------------------------------------------------------
	// Row counter FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state   <= rec_df_pkg::SEQ_IDLE;
			row_cnt <= 2'd0;
		end
		else if (blk_start)
		begin
			// New block, also restarts a running one
			state   <= rec_df_pkg::SEQ_RUN;
			row_cnt <= 2'd0;
		end
		else
		begin
			case (state)
				rec_df_pkg::SEQ_IDLE:
				begin
					row_cnt <= 2'd0;
				end
				rec_df_pkg::SEQ_RUN:
				begin
					// Last row written, back to idle
					if (row_cnt == 2'd3)
					begin
						state   <= rec_df_pkg::SEQ_IDLE;
						row_cnt <= 2'd0;
					end
					else
					begin
						row_cnt <= row_cnt + 2'd1;
					end
				end
				default:
				begin
					state <= rec_df_pkg::SEQ_IDLE;
				end
			endcase
		end
	end

	// Raster block number held for the four rows
	always_ff @(posedge clk)
	begin
		if (blk_start)
		begin
			blk_latched <= blk_index;
		end
	end

	// One row per cycle while running
	assign wr_active = (state == rec_df_pkg::SEQ_RUN);

endmodule

/* rec_df_buffer_checker.sv */
`timescale 1ns/1ps

module rec_df_buffer_checker (
	input logic                 clk,
	input logic                 reset_n,
	input rec_df_pkg::ram_req_t ram0_req,
	input rec_df_pkg::ram_req_t ram1_req,
	input logic                 df_dout_valid
);

	// Any bank being read this cycle
	logic rd_any;

	assign rd_any = ram0_req.rd || ram1_req.rd;

	// ----------------------------------------------------------------------
	// Port usage
	// ----------------------------------------------------------------------
	// Single port allows one operation per cycle
	a_bank0_one_op: assert property (@(posedge clk) disable iff (!reset_n)
		!(ram0_req.wr && ram0_req.rd)) else $error("bank0 wr and rd together");
	a_bank1_one_op: assert property (@(posedge clk) disable iff (!reset_n)
		!(ram1_req.wr && ram1_req.rd)) else $error("bank1 wr and rd together");

	// At most one writer and one reader
	a_one_writer: assert property (@(posedge clk) disable iff (!reset_n)
		!(ram0_req.wr && ram1_req.wr)) else $error("both banks written");
	a_one_reader: assert property (@(posedge clk) disable iff (!reset_n)
		!(ram0_req.rd && ram1_req.rd)) else $error("both banks read");

	// ----------------------------------------------------------------------
	// Read return timing and reset
	// ----------------------------------------------------------------------
	a_valid_lag: assert property (@(posedge clk) disable iff (!reset_n)
		rd_any |=> df_dout_valid) else $error("read without valid one cycle later");
	a_valid_src: assert property (@(posedge clk) disable iff (!reset_n)
		!rd_any |=> !df_dout_valid) else $error("valid without a read before it");

	// Strobes quiet once a reset edge has passed
	a_reset_quiet: assert property (@(posedge clk)
		!reset_n |=> !(ram0_req.wr || ram0_req.rd || ram1_req.wr || ram1_req.rd
		|| df_dout_valid)) else $error("strobe active during reset");

endmodule

bind rec_df_ram_ctrl rec_df_buffer_checker u_checker (
	.clk           (clk),
	.reset_n       (reset_n),
	.ram0_req      (ram0_req),
	.ram1_req      (ram1_req),
	.df_dout_valid (df_dout_valid)
);

/* rec_df_buffer_top.sv */
`timescale 1ns/1ps

module rec_df_buffer_top (
	input  logic                              clk,
	input  logic                              reset_n,
	input  logic                              disable_df,
	input  logic                              end_of_mb,
	input  logic                              blk_start,
	input  logic [4:0]                        blk_index,
	input  rec_df_pkg::pixel_row_t            rec_row,
	input  logic                              df_start,
	output logic                              df_busy,
	output logic [rec_df_pkg::RAM_DATA_W-1:0] df_dout,
	output logic                              df_dout_valid
);

	// Writer outputs
	logic       wr_active;
	logic [1:0] row_cnt;
	logic [4:0] blk_latched;

	// Sequencer outputs
	logic       seq_active;
	logic [5:0] edge_cnt;
	logic [1:0] line_cnt;

	// Bank ports
	rec_df_pkg::ram_req_t              ram0_req;
	rec_df_pkg::ram_req_t              ram1_req;
	logic [rec_df_pkg::RAM_DATA_W-1:0] ram0_dout;
	logic [rec_df_pkg::RAM_DATA_W-1:0] ram1_dout;

	assign df_busy = seq_active;

	rec_blk_writer u_writer (
		.clk         (clk),
		.reset_n     (reset_n),
		.blk_start   (blk_start),
		.blk_index   (blk_index),
		.wr_active   (wr_active),
		.row_cnt     (row_cnt),
		.blk_latched (blk_latched)
	);

	df_edge_sequencer u_sequencer (
		.clk        (clk),
		.reset_n    (reset_n),
		.df_start   (df_start),
		.seq_active (seq_active),
		.edge_cnt   (edge_cnt),
		.line_cnt   (line_cnt)
	);

	rec_df_ram_ctrl u_ctrl (
		.clk           (clk),
		.reset_n       (reset_n),
		.disable_df    (disable_df),
		.end_of_mb     (end_of_mb),
		.wr_active     (wr_active),
		.row_cnt       (row_cnt),
		.blk_latched   (blk_latched),
		.rec_row       (rec_row),
		.seq_active    (seq_active),
		.edge_cnt      (edge_cnt),
		.line_cnt      (line_cnt),
		.ram0_dout     (ram0_dout),
		.ram1_dout     (ram1_dout),
		.ram0_req      (ram0_req),
		.ram1_req      (ram1_req),
		.df_dout       (df_dout),
		.df_dout_valid (df_dout_valid)
	);

	// Ping-pong pair
	rec_df_ram bank0 (
		.clk  (clk),
		.req  (ram0_req),
		.dout (ram0_dout)
	);

	rec_df_ram bank1 (
		.clk  (clk),
		.req  (ram1_req),
		.dout (ram1_dout)
	);

endmodule

/* rec_df_pkg.sv */
package rec_df_pkg;

	// ----------------------------------------------------------------------
	// Sizes of one ping-pong bank
	// ----------------------------------------------------------------------
	// Word address width, one bank
	localparam int RAM_ADDR_W = 7;
	// Four 8-bit pixels per word
	localparam int RAM_DATA_W = 32;
	localparam int RAM_DEPTH  = 128;

	// 16 luma + 8 chroma 4x4 blocks, 96 words used
	localparam int BLK_NUM   = 24;
	// Filter walks edges 0 to 47
	localparam int EDGE_LAST = 47;

	// ----------------------------------------------------------------------
	// Types
	// ----------------------------------------------------------------------
	// One row of a 4x4 block, p0 in the low byte
	typedef struct packed {
		logic [7:0] p3;
		logic [7:0] p2;
		logic [7:0] p1;
		logic [7:0] p0;
	} pixel_row_t;

	// Port request to one bank
	typedef struct packed {
		logic                  wr;
		logic                  rd;
		logic [RAM_ADDR_W-1:0] addr;
		logic [RAM_DATA_W-1:0] din;
	} ram_req_t;

	// Shared by row writer and edge sequencer
	typedef enum logic {
		SEQ_IDLE,
		SEQ_RUN
	} seq_state_e;

	// Bank currently taking reconstruction writes
	typedef enum logic {
		BANK0_REC,
		BANK1_REC
	} bank_sel_e;

endpackage

/* rec_df_ram.sv */
`timescale 1ns/1ps

module rec_df_ram (
	input  logic                              clk,
	input  rec_df_pkg::ram_req_t              req,
	output logic [rec_df_pkg::RAM_DATA_W-1:0] dout
);

	// Storage for one macroblock of reconstructed rows
	logic [rec_df_pkg::RAM_DATA_W-1:0] mem [rec_df_pkg::RAM_DEPTH];

	// Single port, write side
	always_ff @(posedge clk)
	begin
		if (req.wr)
		begin
			mem[req.addr] <= req.din;
		end
	end

	// Registered read, one cycle latency
	// dout keeps last word when idle
	always_ff @(posedge clk)
	begin
		if (req.rd)
		begin
			dout <= mem[req.addr];
		end
	end

endmodule

/* rec_df_ram_ctrl.sv */
`timescale 1ns/1ps

module rec_df_ram_ctrl (
	input  logic                              clk,
	input  logic                              reset_n,
	input  logic                              disable_df,
	input  logic                              end_of_mb,
	input  logic                              wr_active,
	input  logic [1:0]                        row_cnt,
	input  logic [4:0]                        blk_latched,
	input  rec_df_pkg::pixel_row_t            rec_row,
	input  logic                              seq_active,
	input  logic [5:0]                        edge_cnt,
	input  logic [1:0]                        line_cnt,
	input  logic [rec_df_pkg::RAM_DATA_W-1:0] ram0_dout,
	input  logic [rec_df_pkg::RAM_DATA_W-1:0] ram1_dout,
	output rec_df_pkg::ram_req_t              ram0_req,
	output rec_df_pkg::ram_req_t              ram1_req,
	output logic [rec_df_pkg::RAM_DATA_W-1:0] df_dout,
	output logic                              df_dout_valid
);

	rec_df_pkg::bank_sel_e bank_sel;
	rec_df_pkg::bank_sel_e rd_bank_q;
	rec_df_pkg::ram_req_t  wr_req;
	rec_df_pkg::ram_req_t  rd_req;

	logic       wr_en;
	logic       rd_en;
	logic       rd_hit;
	logic [4:0] rd_blk;
	logic       rd_q;

	// ----------------------------------------------------------------------
	// Write side, reconstruction rows
	// ----------------------------------------------------------------------
	// Nothing stored when the filter is bypassed
	assign wr_en = wr_active && !disable_df && (blk_latched < 5'(rec_df_pkg::BLK_NUM));

	always_comb
	begin
		wr_req      = '0;
		wr_req.wr   = wr_en;
		// Word address is block * 4 + row
		wr_req.addr = wr_en ? {blk_latched, row_cnt} : '0;
		wr_req.din  = wr_en ? rec_row : '0;
	end

	// ----------------------------------------------------------------------
	// Read side, filter edge order
	// ----------------------------------------------------------------------
	// Only edges that own a block fetch it
	always_comb
	begin
		rd_hit = 1'b1;
		case (edge_cnt)
			// Luma top half
			6'd0:  rd_blk = 5'd0;
			6'd1:  rd_blk = 5'd1;
			6'd2:  rd_blk = 5'd4;
			6'd3:  rd_blk = 5'd5;
			6'd6:  rd_blk = 5'd2;
			6'd7:  rd_blk = 5'd6;
			6'd10: rd_blk = 5'd3;
			6'd11: rd_blk = 5'd7;
			// Luma bottom half, same pattern + 8
			6'd16: rd_blk = 5'd8;
			6'd17: rd_blk = 5'd9;
			6'd18: rd_blk = 5'd12;
			6'd19: rd_blk = 5'd13;
			6'd22: rd_blk = 5'd10;
			6'd23: rd_blk = 5'd14;
			6'd26: rd_blk = 5'd11;
			6'd27: rd_blk = 5'd15;
			// Cb
			6'd32: rd_blk = 5'd16;
			6'd33: rd_blk = 5'd17;
			6'd34: rd_blk = 5'd18;
			6'd35: rd_blk = 5'd19;
			// Cr
			6'd40: rd_blk = 5'd20;
			6'd41: rd_blk = 5'd21;
			6'd42: rd_blk = 5'd22;
			6'd43: rd_blk = 5'd23;
			default:
			begin
				rd_hit = 1'b0;
				rd_blk = 5'd0;
			end
		endcase
	end

	assign rd_en = seq_active && rd_hit;

	always_comb
	begin
		rd_req      = '0;
		rd_req.rd   = rd_en;
		// Block * 4 + line within edge
		rd_req.addr = rd_en ? {rd_blk, line_cnt} : '0;
	end

	// ----------------------------------------------------------------------
	// Ping-pong bank select
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			bank_sel <= rec_df_pkg::BANK0_REC;
		end
		else if (end_of_mb)
		begin
			bank_sel <= (bank_sel == rec_df_pkg::BANK0_REC) ?
				rec_df_pkg::BANK1_REC : rec_df_pkg::BANK0_REC;
		end
	end

	// Writes to the rec bank, reads from the other one
	always_comb
	begin
		if (bank_sel == rec_df_pkg::BANK0_REC)
		begin
			ram0_req = wr_req;
			ram1_req = rd_req;
		end
		else
		begin
			ram0_req = rd_req;
			ram1_req = wr_req;
		end
	end

	// ----------------------------------------------------------------------
	// Read return path
	// ----------------------------------------------------------------------
	// Select captured with the request, a swap in flight is harmless
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			rd_q      <= 1'b0;
			rd_bank_q <= rec_df_pkg::BANK0_REC;
		end
		else
		begin
			rd_q <= rd_en;
			if (rd_en)
			begin
				rd_bank_q <= bank_sel;
			end
		end
	end

	// BANK0_REC meant bank1 was read
	assign df_dout       = (rd_bank_q == rec_df_pkg::BANK0_REC) ? ram1_dout : ram0_dout;
	assign df_dout_valid = rd_q;

endmodule

/* tb_rec_df_buffer.sv */
`timescale 1ns/1ps

module tb_rec_df_buffer;

	// Words per macroblock and busy length of one filter pass
	localparam int MB_WORDS  = 4 * rec_df_pkg::BLK_NUM;
	localparam int DF_CYCLES = 4 * (rec_df_pkg::EDGE_LAST + 1);
	// Tests need about 1300 cycles so this leaves a threefold margin
	localparam int TIMEOUT_CYCLES = 4000;

	logic                   clk;
	logic                   reset_n;
	logic                   disable_df;
	logic                   end_of_mb;
	logic                   blk_start;
	logic [4:0]             blk_index;
	rec_df_pkg::pixel_row_t rec_row;
	logic                   df_start;
	logic                   df_busy;
	logic [31:0]            df_dout;
	logic                   df_dout_valid;

	// Reference copy of both banks
	logic [31:0] model_mem [2][rec_df_pkg::RAM_DEPTH];
	// Index of the bank taking writes
	int          model_rec;
	logic [31:0] rng_state;
	int          err_cnt;
	int          cycle_cnt;

	// Block fetch order of the filter edges
	int read_order [24] = '{0, 1, 4, 5, 2, 6, 3, 7, 8, 9, 12, 13, 10, 14, 11, 15,
		16, 17, 18, 19, 20, 21, 22, 23};

	rec_df_buffer_top UUT (
		.clk           (clk),
		.reset_n       (reset_n),
		.disable_df    (disable_df),
		.end_of_mb     (end_of_mb),
		.blk_start     (blk_start),
		.blk_index     (blk_index),
		.rec_row       (rec_row),
		.df_start      (df_start),
		.df_busy       (df_busy),
		.df_dout       (df_dout),
		.df_dout_valid (df_dout_valid)
	);

	// 8 ns clock
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Watchdog
	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------
	// 24 blocks in raster order with five cycles each
	task automatic write_mb();
		int          b;
		int          r;
		logic [31:0] row;
		for (b = 0; b < rec_df_pkg::BLK_NUM; b++)
		begin
			@(posedge clk);
			blk_start <= 1'b1;
			blk_index <= 5'(b);
			for (r = 0; r < 4; r++)
			begin
				@(posedge clk);
				blk_start <= 1'b0;
				rng_state = xorshift32(rng_state);
				row = rng_state;
				rec_row <= row;
				// Bypassed filter leaves the bank untouched
				if (!disable_df)
				begin
					model_mem[model_rec][b * 4 + r] = row;
				end
			end
		end
		// Final row lands on this edge
		@(posedge clk);
	endtask

	task automatic swap_banks();
		@(posedge clk);
		end_of_mb <= 1'b1;
		@(posedge clk);
		end_of_mb <= 1'b0;
		model_rec = 1 - model_rec;
	endtask

	// One filter pass checked word by word against the read bank
	task automatic run_df();
		int          rbank;
		int          idx;
		int          busy_cycles;
		int          n;
		bit          seen_busy;
		bit          done;
		logic [31:0] exp;
		rbank       = 1 - model_rec;
		idx         = 0;
		busy_cycles = 0;
		n           = 0;
		seen_busy   = 1'b0;
		done        = 1'b0;
		@(posedge clk);
		df_start <= 1'b1;
		@(posedge clk);
		df_start <= 1'b0;
		// Sample mid-cycle away from the edge
		while (!done && n < DF_CYCLES + 100)
		begin
			@(negedge clk);
			n++;
			if (df_busy)
			begin
				busy_cycles++;
				seen_busy = 1'b1;
			end
			else if (seen_busy)
			begin
				done = 1'b1;
			end
			if (df_dout_valid)
			begin
				if (idx >= MB_WORDS)
				begin
					err_cnt++;
					$display("more valid words than one macroblock holds");
				end
				else
				begin
					exp = model_mem[rbank][read_order[idx / 4] * 4 + idx % 4];
					if (df_dout !== exp)
					begin
						err_cnt++;
						$display("mismatch df_dout word %0d: got %h expected %h",
							idx, df_dout, exp);
					end
				end
				idx++;
			end
		end
		if (!done)
		begin
			err_cnt++;
			$display("df_busy did not complete a pass after df_start");
		end
		if (busy_cycles != DF_CYCLES)
		begin
			err_cnt++;
			$display("mismatch df_busy cycles: got %h expected %h", busy_cycles, DF_CYCLES);
		end
		if (idx != MB_WORDS)
		begin
			err_cnt++;
			$display("mismatch df_dout_valid count: got %h expected %h", idx, MB_WORDS);
		end
	endtask

	// ----------------------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------------------
	task automatic check_idle();
		int i;
		for (i = 0; i < 20; i++)
		begin
			@(negedge clk);
			if (df_busy !== 1'b0)
			begin
				err_cnt++;
				$display("mismatch df_busy: got %h expected %h", df_busy, 1'b0);
			end
			if (df_dout_valid !== 1'b0)
			begin
				err_cnt++;
				$display("mismatch df_dout_valid: got %h expected %h", df_dout_valid, 1'b0);
			end
		end
	endtask

	// Bank 0 filled then swapped and read back
	task automatic fill_then_read();
		write_mb();
		swap_banks();
		run_df();
	endtask

	// New MB into bank 1 while bank 0 is filtered
	task automatic write_during_read();
		fork
			write_mb();
			run_df();
		join
		swap_banks();
		run_df();
	endtask

	task automatic write_while_disabled();
		@(posedge clk);
		disable_df <= 1'b1;
		write_mb();
		@(posedge clk);
		disable_df <= 1'b0;
		swap_banks();
		run_df();
	endtask

	// Two swaps land back on the same read bank
	task automatic double_swap_reread();
		swap_banks();
		swap_banks();
		run_df();
	endtask

	initial
	begin
		reset_n    = 1'b0;
		disable_df = 1'b0;
		end_of_mb  = 1'b0;
		blk_start  = 1'b0;
		blk_index  = 5'd0;
		rec_row    = '0;
		df_start   = 1'b0;
		model_rec  = 0;
		rng_state  = 32'he73ec201;
		err_cnt    = 0;
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;

		check_idle();
		fill_then_read();
		write_during_read();
		write_while_disabled();
		double_swap_reread();

		$display("errors: %0d", err_cnt);
		if (err_cnt == 0)
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
